// File: design/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// byte address and block geometry
`define DCACHE_ADDR_BITS 16
`define DCACHE_BLOCK_BITS 64
`define DCACHE_OFFSET_BITS 3

`define DCACHE_SETS 8
`define DCACHE_INDEX_BITS 3
`define DCACHE_TAG_BITS (`DCACHE_ADDR_BITS - `DCACHE_INDEX_BITS - `DCACHE_OFFSET_BITS)
// one lru bit per set, so two ways only
`define DCACHE_WAYS 2

`define MEM_TAG_BITS 4

`endif

// File: design/dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

	typedef enum logic [1:0] {
		PROC_NONE  = 2'd0,
		PROC_LOAD  = 2'd1,
		PROC_STORE = 2'd2
	} proc_command_t;

	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_command_t;

	// zero means no tag
	typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

	typedef struct packed {
		proc_command_t command;
		logic [`DCACHE_ADDR_BITS-1:0] addr;
		logic [`DCACHE_BLOCK_BITS-1:0] data;
	} dcache_req_t;

	// block address is tag and index
	typedef struct packed {
		mem_command_t command;
		logic [`DCACHE_TAG_BITS+`DCACHE_INDEX_BITS-1:0] block_addr;
		logic [`DCACHE_BLOCK_BITS-1:0] data;
	} mem_req_t;

	typedef struct packed {
		logic valid;
		logic [`DCACHE_BLOCK_BITS-1:0] data;
	} mem_fill_t;

endpackage

// File: design/dcache_request_latch.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_request_latch (
	input  logic clock,
	input  logic reset,
	input  dcache_pkg::proc_command_t proc_command,
	input  logic [`DCACHE_ADDR_BITS-1:0] proc_addr,
	input  logic [`DCACHE_BLOCK_BITS-1:0] proc_data,
	input  logic done,
	output logic proc_ready,
	output dcache_pkg::dcache_req_t request,
	output logic request_valid
);
	import dcache_pkg::*;

	logic busy;
	logic accept;

	assign accept = !busy && (proc_command != PROC_NONE);
	assign proc_ready = !busy;
	assign request_valid = busy;

	// busy from the accepting edge until the edge that sees done
	always_ff @(posedge clock)
	begin
		if (reset)
			busy <= 1'b0;
		else if (accept)
			busy <= 1'b1;
		else if (done)
			busy <= 1'b0;
	end

	// held stable while the request is in flight
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			request.command <= proc_command;
			request.addr <= proc_addr;
			request.data <= proc_data;
		end
	end

	a_done_only_when_busy: assert property (
		@(posedge clock) disable iff (reset)
		done |-> busy
	);

endmodule

// File: design/dcache_mem.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_mem (
	input  logic clock,
	input  logic reset,
	input  dcache_pkg::dcache_req_t request,
	input  logic request_valid,
	input  logic mem_accepted,
	input  dcache_pkg::mem_fill_t fill,
	output dcache_pkg::mem_req_t mem_request,
	output logic done,
	output logic [`DCACHE_BLOCK_BITS-1:0] load_data
);
	import dcache_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_WRITEBACK,
		S_FILL_WAIT,
		S_RESPOND
	} state_t;

	state_t state;

	logic [`DCACHE_TAG_BITS-1:0] tags [`DCACHE_SETS][`DCACHE_WAYS];
	logic [`DCACHE_BLOCK_BITS-1:0] blocks [`DCACHE_SETS][`DCACHE_WAYS];
	logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] valid;
	logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] dirty;
	// way to replace next
	logic [`DCACHE_SETS-1:0] lru;

	logic [`DCACHE_INDEX_BITS-1:0] index;
	logic [`DCACHE_TAG_BITS-1:0] tag;
	logic [`DCACHE_WAYS-1:0] way_hit;
	logic hit;
	logic hit_way;
	logic is_store;
	logic evict;
	logic victim;

	mem_command_t req_command;
	logic [`DCACHE_TAG_BITS+`DCACHE_INDEX_BITS-1:0] req_block_addr;
	logic [`DCACHE_BLOCK_BITS-1:0] req_data;

	assign index = request.addr[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS];
	assign tag = request.addr[`DCACHE_ADDR_BITS-1 -: `DCACHE_TAG_BITS];
	assign is_store = (request.command == PROC_STORE);

	always_comb
	begin
		for (int w = 0; w < `DCACHE_WAYS; w++)
			way_hit[w] = valid[index][w] && (tags[index][w] == tag);
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1];
	assign evict = valid[index][lru[index]] && dirty[index][lru[index]];

	assign mem_request = '{command: req_command, block_addr: req_block_addr, data: req_data};

	assign done = ((state == S_LOOKUP) && hit) || (state == S_RESPOND);

	always_comb
	begin
		load_data = '0;
		if (!is_store)
		begin
			if ((state == S_LOOKUP) && hit)
				load_data = blocks[index][hit_way];
			else if (state == S_RESPOND)
				load_data = blocks[index][victim];
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			req_command <= MEM_NONE;
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (request_valid)
						state <= S_LOOKUP;
				S_LOOKUP:
					if (hit)
					begin
						lru[index] <= !hit_way;
						if (is_store)
							dirty[index][hit_way] <= 1'b1;
						state <= S_IDLE;
					end
					else if (evict)
					begin
						req_command <= MEM_STORE;
						state <= S_WRITEBACK;
					end
					else
					begin
						req_command <= MEM_LOAD;
						state <= S_FILL_WAIT;
					end
				S_WRITEBACK:
					if (mem_accepted)
					begin
						req_command <= MEM_LOAD;
						state <= S_FILL_WAIT;
					end
				S_FILL_WAIT:
				begin
					if (mem_accepted)
						req_command <= MEM_NONE;
					if (fill.valid)
					begin
						valid[index][victim] <= 1'b1;
						dirty[index][victim] <= is_store;
						lru[index] <= !victim;
						state <= S_RESPOND;
					end
				end
				S_RESPOND:
					state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// tags, blocks and outgoing payload
	always_ff @(posedge clock)
	begin
		if (state == S_LOOKUP)
		begin
			victim <= lru[index];
			if (hit && is_store)
				blocks[index][hit_way] <= request.data;
			if (evict)
			begin
				req_block_addr <= {tags[index][lru[index]], index};
				req_data <= blocks[index][lru[index]];
			end
			else
			begin
				req_block_addr <= {tag, index};
				req_data <= '0;
			end
		end
		if ((state == S_WRITEBACK) && mem_accepted)
		begin
			req_block_addr <= {tag, index};
			req_data <= '0;
		end
		if ((state == S_FILL_WAIT) && fill.valid)
		begin
			tags[index][victim] <= tag;
			// a store miss overwrites the whole fetched block
			blocks[index][victim] <= is_store ? request.data : fill.data;
		end
	end

	a_accept_has_request: assert property (
		@(posedge clock) disable iff (reset)
		mem_accepted |-> (mem_request.command != MEM_NONE)
	);

	a_fill_in_wait: assert property (
		@(posedge clock) disable iff (reset)
		fill.valid |-> (state == S_FILL_WAIT)
	);

endmodule

// File: design/dcache_mem_port.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_mem_port (
	input  logic clock,
	input  logic reset,
	input  dcache_pkg::mem_req_t mem_request,
	input  dcache_pkg::mem_tag_t mem_response,
	input  dcache_pkg::mem_tag_t mem_tag,
	input  logic [`DCACHE_BLOCK_BITS-1:0] mem_load_data,
	output dcache_pkg::mem_command_t mem_command,
	output logic [`DCACHE_ADDR_BITS-1:0] mem_addr,
	output logic [`DCACHE_BLOCK_BITS-1:0] mem_data,
	output logic mem_accepted,
	output dcache_pkg::mem_fill_t fill
);
	import dcache_pkg::*;

	mem_tag_t load_tag;
	logic load_pending;
	logic issue;
	logic fill_match;

	// a nonzero response takes the command
	assign mem_accepted = (mem_command != MEM_NONE) && (mem_response != '0);

	// pins idle, no load outstanding
	assign issue = (mem_command == MEM_NONE) && !load_pending
		&& (mem_request.command != MEM_NONE);

	assign fill_match = load_pending && (mem_tag != '0) && (mem_tag == load_tag);
	assign fill = '{valid: fill_match, data: mem_load_data};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			mem_command <= MEM_NONE;
			load_pending <= 1'b0;
		end
		else
		begin
			// refused commands just stay on the pins
			if (issue)
				mem_command <= mem_request.command;
			else if (mem_accepted)
				mem_command <= MEM_NONE;

			if (mem_accepted && (mem_command == MEM_LOAD))
				load_pending <= 1'b1;
			else if (fill_match)
				load_pending <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (issue)
		begin
			mem_addr <= {mem_request.block_addr, {`DCACHE_OFFSET_BITS{1'b0}}};
			mem_data <= mem_request.data;
		end
		if (mem_accepted)
			load_tag <= mem_response;
	end

	// only one miss in flight
	a_no_request_during_load: assert property (
		@(posedge clock) disable iff (reset)
		load_pending |-> (mem_request.command == MEM_NONE)
	);

endmodule

// File: design/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top (
	input  logic clock,
	input  logic reset,
	input  dcache_pkg::proc_command_t proc_command,
	input  logic [`DCACHE_ADDR_BITS-1:0] proc_addr,
	input  logic [`DCACHE_BLOCK_BITS-1:0] proc_data,
	output logic proc_ready,
	output logic proc_done,
	output logic [`DCACHE_BLOCK_BITS-1:0] proc_load_data,
	output dcache_pkg::mem_command_t mem_command,
	output logic [`DCACHE_ADDR_BITS-1:0] mem_addr,
	output logic [`DCACHE_BLOCK_BITS-1:0] mem_data,
	input  dcache_pkg::mem_tag_t mem_response,
	input  dcache_pkg::mem_tag_t mem_tag,
	input  logic [`DCACHE_BLOCK_BITS-1:0] mem_load_data
);
	import dcache_pkg::*;

	dcache_req_t request;
	logic request_valid;
	mem_req_t mem_request;
	logic mem_accepted;
	mem_fill_t fill;

	dcache_request_latch i_request_latch (
		.clock(clock),
		.reset(reset),
		.proc_command(proc_command),
		.proc_addr(proc_addr),
		.proc_data(proc_data),
		.done(proc_done),
		.proc_ready(proc_ready),
		.request(request),
		.request_valid(request_valid)
	);

	dcache_mem i_mem (
		.clock(clock),
		.reset(reset),
		.request(request),
		.request_valid(request_valid),
		.mem_accepted(mem_accepted),
		.fill(fill),
		.mem_request(mem_request),
		.done(proc_done),
		.load_data(proc_load_data)
	);

	dcache_mem_port i_mem_port (
		.clock(clock),
		.reset(reset),
		.mem_request(mem_request),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.mem_load_data(mem_load_data),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_accepted(mem_accepted),
		.fill(fill)
	);

endmodule

// File: testbench/dcache_mem_model.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_mem_model (
	input  logic clock,
	input  logic reset,
	input  dcache_pkg::mem_command_t mem_command,
	input  logic [`DCACHE_ADDR_BITS-1:0] mem_addr,
	input  logic [`DCACHE_BLOCK_BITS-1:0] mem_data,
	output dcache_pkg::mem_tag_t mem_response,
	output dcache_pkg::mem_tag_t mem_tag,
	output logic [`DCACHE_BLOCK_BITS-1:0] mem_load_data
);
	import dcache_pkg::*;

	localparam int BLOCKS = 1 << (`DCACHE_ADDR_BITS - `DCACHE_OFFSET_BITS);

	logic [`DCACHE_BLOCK_BITS-1:0] words [BLOCKS];
	logic [`DCACHE_ADDR_BITS-`DCACHE_OFFSET_BITS-1:0] return_block;
	mem_tag_t next_tag;
	mem_tag_t return_tag;
	logic pending;
	int delay;

	function automatic logic [63:0] initial_word(input logic [12:0] blk);
		return {blk, 3'b101, ~blk, 3'b011, 16'hc3a5 ^ {3'b000, blk}, blk, 3'b000};
	endfunction

	initial
	begin
		for (int i = 0; i < BLOCKS; i++)
			words[i] = initial_word(i[12:0]);
		mem_response = '0;
		mem_tag = '0;
		mem_load_data = '0;
	end

	// responses change on the falling edge only
	always @(negedge clock)
	begin
		if (reset)
		begin
			mem_response = '0;
			mem_tag = '0;
			pending = 1'b0;
			next_tag = 4'd1;
		end
		else
		begin
			mem_tag = '0;
			if (pending)
			begin
				delay = delay - 1;
				if (delay == 0)
				begin
					mem_tag = return_tag;
					mem_load_data = words[return_block];
					pending = 1'b0;
				end
			end
			// refuse about one command in four
			if ((mem_command != MEM_NONE) && (($urandom % 4) != 0))
			begin
				mem_response = next_tag;
				if (mem_command == MEM_STORE)
					words[mem_addr[15:3]] = mem_data;
				else
				begin
					pending = 1'b1;
					return_tag = next_tag;
					return_block = mem_addr[15:3];
					delay = 2 + int'($urandom % 5);
				end
				next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
			else
				mem_response = '0;
		end
	end

endmodule

// File: testbench/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tb;
	import dcache_pkg::*;

	localparam int TIMEOUT = 200;
	localparam int STEPS = 17;

	typedef struct packed {
		proc_command_t command;
		logic [15:0] addr;
		logic [63:0] data;
		logic hit;
	} step_t;

	logic clock;
	logic reset;
	proc_command_t proc_command;
	logic [`DCACHE_ADDR_BITS-1:0] proc_addr;
	logic [`DCACHE_BLOCK_BITS-1:0] proc_data;
	logic proc_ready;
	logic proc_done;
	logic [`DCACHE_BLOCK_BITS-1:0] proc_load_data;
	mem_command_t mem_command;
	logic [`DCACHE_ADDR_BITS-1:0] mem_addr;
	logic [`DCACHE_BLOCK_BITS-1:0] mem_data;
	mem_tag_t mem_response;
	mem_tag_t mem_tag;
	logic [`DCACHE_BLOCK_BITS-1:0] mem_load_data;

	// set 1 tags 0x0008, 0x0048, 0x0088, 0x00c8, 0x0108, 0x0148 collide
	step_t steps [STEPS] = '{
		'{PROC_LOAD,  16'h0008, 64'h0, 1'b0},
		'{PROC_LOAD,  16'h0010, 64'h0, 1'b0},
		'{PROC_LOAD,  16'h0008, 64'h0, 1'b1},
		'{PROC_STORE, 16'h0008, 64'h1111_2222_3333_4444, 1'b1},
		'{PROC_LOAD,  16'h0008, 64'h0, 1'b1},
		'{PROC_LOAD,  16'h0048, 64'h0, 1'b0},
		'{PROC_LOAD,  16'h0088, 64'h0, 1'b0},
		'{PROC_LOAD,  16'h0008, 64'h0, 1'b0},
		'{PROC_STORE, 16'h1010, 64'hdead_beef_0bad_f00d, 1'b0},
		'{PROC_LOAD,  16'h1010, 64'h0, 1'b1},
		'{PROC_LOAD,  16'h0088, 64'h0, 1'b1},
		'{PROC_STORE, 16'h00c8, 64'h0123_4567_89ab_cdef, 1'b0},
		'{PROC_LOAD,  16'h0108, 64'h0, 1'b0},
		'{PROC_LOAD,  16'h0148, 64'h0, 1'b0},
		'{PROC_LOAD,  16'h00c8, 64'h0, 1'b0},
		'{PROC_LOAD,  16'h0010, 64'h0, 1'b1},
		'{PROC_LOAD,  16'h03f8, 64'h0, 1'b0}
	};

	// reference cache
	logic [`DCACHE_TAG_BITS-1:0] ref_tag [`DCACHE_SETS][2];
	logic [63:0] ref_block [`DCACHE_SETS][2];
	logic ref_valid [`DCACHE_SETS][2];
	logic ref_dirty [`DCACHE_SETS][2];
	logic ref_lru [`DCACHE_SETS];
	logic [63:0] ref_mem [logic [12:0]];

	int errors;
	int steps_run;
	logic timed_out;

	// memory pin observations
	logic load_seen;
	logic store_before_load;
	int store_count;
	logic [15:0] store_addr;
	logic [63:0] store_data;
	logic refused;
	mem_command_t held_command;
	logic [15:0] held_addr;
	logic [63:0] held_data;

	dcache_top i_dut (
		.clock(clock),
		.reset(reset),
		.proc_command(proc_command),
		.proc_addr(proc_addr),
		.proc_data(proc_data),
		.proc_ready(proc_ready),
		.proc_done(proc_done),
		.proc_load_data(proc_load_data),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.mem_load_data(mem_load_data)
	);

	dcache_mem_model i_mem_model (
		.clock(clock),
		.reset(reset),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.mem_load_data(mem_load_data)
	);

	initial
		clock = 1'b0;

	always #4 clock = ~clock;

	// same fill pattern as the memory model holds at start
	function automatic logic [63:0] initial_word(input logic [12:0] blk);
		return {blk, 3'b101, ~blk, 3'b011, 16'hc3a5 ^ {3'b000, blk}, blk, 3'b000};
	endfunction

	function automatic logic [63:0] memory_word(input logic [12:0] blk);
		if (ref_mem.exists(blk))
			return ref_mem[blk];
		return initial_word(blk);
	endfunction

	task automatic ref_access(input step_t s, output logic hit, output logic wb,
		output logic [15:0] wb_addr, output logic [63:0] wb_data, output logic [63:0] data);
		logic [2:0] idx;
		logic [9:0] tag;
		logic way;
		idx = s.addr[5:3];
		tag = s.addr[15:6];
		hit = 1'b0;
		wb = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		way = ref_lru[idx];
		for (int w = 0; w < 2; w++)
		begin
			if (ref_valid[idx][w] && (ref_tag[idx][w] == tag))
			begin
				hit = 1'b1;
				way = w[0];
			end
		end
		if (!hit)
		begin
			if (ref_valid[idx][way] && ref_dirty[idx][way])
			begin
				wb = 1'b1;
				wb_addr = {ref_tag[idx][way], idx, 3'b000};
				wb_data = ref_block[idx][way];
				ref_mem[{ref_tag[idx][way], idx}] = wb_data;
			end
			ref_block[idx][way] = memory_word({tag, idx});
			ref_tag[idx][way] = tag;
			ref_valid[idx][way] = 1'b1;
			ref_dirty[idx][way] = 1'b0;
		end
		if (s.command == PROC_STORE)
		begin
			ref_block[idx][way] = s.data;
			ref_dirty[idx][way] = 1'b1;
			data = '0;
		end
		else
			data = ref_block[idx][way];
		ref_lru[idx] = !way;
	endtask

	// command pins are stable at the rising edge
	always @(posedge clock)
	begin
		if (reset)
			refused = 1'b0;
		else
		begin
			if (refused && (mem_command != held_command))
			begin
				$display("ERR mem_command: expected %h got %h", held_command, mem_command);
				errors++;
			end
			if (refused && (mem_addr != held_addr))
			begin
				$display("ERR mem_addr: expected %h got %h", held_addr, mem_addr);
				errors++;
			end
			if (refused && (mem_data != held_data))
			begin
				$display("ERR mem_data: expected %h got %h", held_data, mem_data);
				errors++;
			end
			if (mem_command == MEM_LOAD)
				load_seen = 1'b1;
			if ((mem_command == MEM_STORE) && (mem_response != '0))
			begin
				store_count++;
				store_addr = mem_addr;
				store_data = mem_data;
				store_before_load = !load_seen;
			end
			refused = (mem_command != MEM_NONE) && (mem_response == '0);
			held_command = mem_command;
			held_addr = mem_addr;
			held_data = mem_data;
		end
	end

	task automatic run_step(input int i);
		logic exp_hit;
		logic exp_wb;
		logic [15:0] exp_wb_addr;
		logic [63:0] exp_wb_data;
		logic [63:0] exp_data;
		int cycles;
		cycles = 0;
		while (!proc_ready)
		begin
			@(negedge clock);
			cycles++;
			if (cycles > TIMEOUT)
			begin
				$display("timeout waiting for proc_ready before step %0d", i);
				timed_out = 1'b1;
				return;
			end
		end
		ref_access(steps[i], exp_hit, exp_wb, exp_wb_addr, exp_wb_data, exp_data);
		if (exp_hit != steps[i].hit)
		begin
			$display("step %0d: table hit flag disagrees with the reference cache", i);
			errors++;
		end
		load_seen = 1'b0;
		store_count = 0;
		store_before_load = 1'b0;
		proc_command = steps[i].command;
		proc_addr = steps[i].addr;
		proc_data = steps[i].data;
		@(negedge clock);
		proc_command = PROC_NONE;
		// the request is held, so ready drops right after the accepting edge
		if (proc_ready)
		begin
			$display("ERR proc_ready: step %0d expected %h got %h", i, 1'b0, proc_ready);
			errors++;
		end
		cycles = 1;
		while (!proc_done)
		begin
			@(negedge clock);
			cycles++;
			if (cycles > TIMEOUT)
			begin
				$display("timeout waiting for proc_done in step %0d", i);
				timed_out = 1'b1;
				return;
			end
		end
		if (proc_ready)
		begin
			$display("ERR proc_ready: step %0d expected %h got %h", i, 1'b0, proc_ready);
			errors++;
		end
		if (load_seen == steps[i].hit)
		begin
			$display("ERR hit: step %0d expected %h got %h", i, steps[i].hit, !load_seen);
			errors++;
		end
		// a hit finishes one cycle after the accepting edge
		if (steps[i].hit && (cycles != 2))
		begin
			$display("ERR proc_done latency: step %0d expected %h got %h", i, 2, cycles);
			errors++;
		end
		if (proc_load_data != exp_data)
		begin
			$display("ERR proc_load_data: step %0d expected %h got %h", i, exp_data,
				proc_load_data);
			errors++;
		end
		if (store_count != (exp_wb ? 1 : 0))
		begin
			$display("ERR writeback count: step %0d expected %h got %h", i, exp_wb,
				store_count);
			errors++;
		end
		else if (exp_wb && ((store_addr != exp_wb_addr) || (store_data != exp_wb_data)))
		begin
			$display("ERR mem_addr/mem_data: step %0d expected %h/%h got %h/%h", i,
				exp_wb_addr, exp_wb_data, store_addr, store_data);
			errors++;
		end
		else if (exp_wb && !store_before_load)
		begin
			$display("step %0d: writeback store came after the fill load", i);
			errors++;
		end
		// ready again in the cycle after done
		@(negedge clock);
		if (!proc_ready)
		begin
			$display("ERR proc_ready: step %0d expected %h got %h", i, 1'b1, proc_ready);
			errors++;
		end
		steps_run++;
	endtask

	initial
	begin
		void'($urandom(32'hadb4));
		errors = 0;
		steps_run = 0;
		timed_out = 1'b0;
		reset = 1'b1;
		proc_command = PROC_NONE;
		proc_addr = '0;
		proc_data = '0;
		for (int s = 0; s < `DCACHE_SETS; s++)
		begin
			ref_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++)
			begin
				ref_valid[s][w] = 1'b0;
				ref_dirty[s][w] = 1'b0;
			end
		end
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		repeat (3)
		begin
			@(negedge clock);
			if (!proc_ready)
			begin
				$display("ERR proc_ready: expected %h got %h", 1'b1, proc_ready);
				errors++;
			end
			if (mem_command != MEM_NONE)
			begin
				$display("ERR mem_command: expected %h got %h", MEM_NONE, mem_command);
				errors++;
			end
		end
		for (int i = 0; i < STEPS; i++)
		begin
			if (!timed_out)
				run_step(i);
		end
		$display("errors: %0d, steps completed: %0d of %0d", errors, steps_run, STEPS);
		if ((errors == 0) && !timed_out)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: project.f
+incdir+design
design/dcache_pkg.sv
design/dcache_request_latch.sv
design/dcache_mem.sv
design/dcache_mem_port.sv
design/dcache_top.sv
testbench/dcache_mem_model.sv
testbench/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= dcache_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SOURCES := $(wildcard design/*.sv design/*.svh testbench/*.sv)
BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
